// File: hw/noc_route_pkg.sv
/*
  shared definitions for the look-ahead XY router of a 4x4 mesh
  holds mesh sizes, port numbering and the packed types passed between blocks
  every RTL and bench file refers to these by scoped name
*/

package noc_route_pkg;

    // mesh size
    localparam int NX = 4;
    localparam int NY = 4;

    // coordinate widths, at least one bit even for a single column or row
    localparam int XW = (NX > 1) ? $clog2(NX) : 1;
    localparam int YW = (NY > 1) ? $clog2(NY) : 1;

    localparam int PORTS  = 5;                   // local plus four directions
    localparam int IDX_W  = $clog2(PORTS);       // binary index over all ports
    localparam int ENC_IW = $clog2(PORTS - 1);   // index into the compacted word

    // port numbering, north is y - 1 and south is y + 1
    localparam int PORT_LOCAL = 0;
    localparam int PORT_EAST  = 1;
    localparam int PORT_NORTH = 2;
    localparam int PORT_WEST  = 3;
    localparam int PORT_SOUTH = 4;

    typedef logic [XW-1:0] coord_x_t;
    typedef logic [YW-1:0] coord_y_t;

    // router address, x in the upper bits
    typedef struct packed {
        coord_x_t x;
        coord_y_t y;
    } coord_t;

    typedef logic [PORTS-1:0] port_onehot_t;

    // one-hot with one port position taken out
    typedef logic [PORTS-2:0] port_enc_t;

    typedef logic [IDX_W-1:0] port_idx_t;

    /*
      request held for one cycle by the control block
      destination router and the output port chosen at this router
    */
    typedef struct packed {
        coord_t       dest;
        port_onehot_t port;
    } route_req_t;

endpackage

// File: hw/lookahead_ctrl.sv
/*
  control stage of the look-ahead router
  registers destination and output port once per clock, rebuilds the
  five-port one-hot around this unit's own position and gives the port
  the packet will arrive on at the next router
*/

`timescale 1ns/100ps

module lookahead_ctrl #(
    parameter int SW_LOC = 0    // input port this unit belongs to
) (
    input  logic                       clk,
    input  logic                       reset,
    input  noc_route_pkg::coord_t      dest,
    input  noc_route_pkg::port_enc_t   destport,
    output noc_route_pkg::route_req_t  req,
    output noc_route_pkg::port_onehot_t recv_port
);

    noc_route_pkg::port_onehot_t port_in;

    // a packet never leaves on the port it came in on, so that bit was
    // dropped upstream; put a zero back at SW_LOC and shift the rest up
    for (genvar i = 0; i < noc_route_pkg::PORTS; i++) begin : g_ins
        if (i < SW_LOC) begin : g_lo
            assign port_in[i] = destport[i];
        end else if (i == SW_LOC) begin : g_own
            assign port_in[i] = 1'b0;
        end else begin : g_hi
            assign port_in[i] = destport[i-1];
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            req <= '0;               // dest (0,0), no port
        end else begin
            req.dest <= dest;
            req.port <= port_in;
        end
    end

    // receive port at the next router is the mirror of our output port
    assign recv_port[noc_route_pkg::PORT_LOCAL] = req.port[noc_route_pkg::PORT_LOCAL];
    assign recv_port[noc_route_pkg::PORT_WEST]  = req.port[noc_route_pkg::PORT_EAST];
    assign recv_port[noc_route_pkg::PORT_EAST]  = req.port[noc_route_pkg::PORT_WEST];
    assign recv_port[noc_route_pkg::PORT_SOUTH] = req.port[noc_route_pkg::PORT_NORTH];
    assign recv_port[noc_route_pkg::PORT_NORTH] = req.port[noc_route_pkg::PORT_SOUTH];

endmodule

// File: hw/next_addr_predictor.sv
/*
  next router address from the current address and the output port
  one step in x or y on a mesh, no wrap at the edges
  purely combinational, used between the control register and the router
*/

`timescale 1ns/100ps

module next_addr_predictor (
    input  noc_route_pkg::coord_t       current,
    input  noc_route_pkg::port_onehot_t port,
    output noc_route_pkg::coord_t       next
);

    always_comb begin
        next = current;   // local or no port keeps the address
        if (port[noc_route_pkg::PORT_EAST]) begin
            next.x = current.x + noc_route_pkg::coord_x_t'(1);
        end else if (port[noc_route_pkg::PORT_NORTH]) begin
            next.y = current.y - noc_route_pkg::coord_y_t'(1);   // north is y - 1
        end else if (port[noc_route_pkg::PORT_WEST]) begin
            next.x = current.x - noc_route_pkg::coord_x_t'(1);
        end else if (port[noc_route_pkg::PORT_SOUTH]) begin
            next.y = current.y + noc_route_pkg::coord_y_t'(1);
        end
    end

endmodule

// File: hw/xy_route.sv
/*
  dimension-order XY routing for one router of the mesh
  x is resolved first, then y, then the packet goes local
  gives a one-hot over all five ports
*/

`timescale 1ns/100ps

module xy_route (
    input  noc_route_pkg::coord_t       here,
    input  noc_route_pkg::coord_t       dest,
    output noc_route_pkg::port_onehot_t port
);

    always_comb begin
        port = '0;
        if (dest.x > here.x) begin
            port[noc_route_pkg::PORT_EAST] = 1'b1;
        end else if (dest.x < here.x) begin
            port[noc_route_pkg::PORT_WEST] = 1'b1;
        end else if (dest.y > here.y) begin
            port[noc_route_pkg::PORT_SOUTH] = 1'b1;    // y grows southward
        end else if (dest.y < here.y) begin
            port[noc_route_pkg::PORT_NORTH] = 1'b1;
        end else begin
            port[noc_route_pkg::PORT_LOCAL] = 1'b1;    // arrived
        end
    end

endmodule

// File: hw/port_compactor.sv
/*
  compacts the look-ahead port to four bits
  the port the packet enters the next router on can never be its exit,
  so that position is taken out and the ports above it move down one
*/

`timescale 1ns/100ps

module port_compactor (
    input  noc_route_pkg::port_onehot_t lk_onehot,
    input  noc_route_pkg::port_onehot_t recv_port,
    output noc_route_pkg::port_enc_t    lkdestport
);

    noc_route_pkg::port_idx_t lk_idx;
    noc_route_pkg::port_idx_t recv_idx;
    noc_route_pkg::port_idx_t out_idx;

    // index of the set bit, 0 when nothing is set
    function automatic noc_route_pkg::port_idx_t onehot_to_idx(
        input noc_route_pkg::port_onehot_t oh
    );
        noc_route_pkg::port_idx_t idx;
        idx = '0;
        for (int i = 0; i < noc_route_pkg::PORTS; i++) begin
            if (oh[i]) begin
                idx = noc_route_pkg::port_idx_t'(i);
            end
        end
        return idx;
    endfunction

    assign lk_idx   = onehot_to_idx(lk_onehot);
    assign recv_idx = onehot_to_idx(recv_port);

    // below the receive port the index stays, at or above it drops by one;
    // local with no receive port wraps to the top position
    assign out_idx = (recv_idx > lk_idx) ? lk_idx
                                         : lk_idx - noc_route_pkg::port_idx_t'(1);

    // back to one-hot over the four remaining positions
    assign lkdestport = noc_route_pkg::port_enc_t'(1) << out_idx[noc_route_pkg::ENC_IW-1:0];

endmodule

// File: hw/lookahead_route_top.sv
/*
  look-ahead XY routing unit for one input port of a mesh router
  the request is registered once, then the next router's address, its
  receive port and its XY decision are worked out in the same cycle
  lkdestport is valid one clock after dest and destport are sampled
*/

`timescale 1ns/100ps

module lookahead_route_top #(
    parameter int SW_LOC = 0    // input port position of this unit
) (
    input  logic                     clk,
    input  logic                     reset,
    input  noc_route_pkg::coord_t    current,    // address of this router
    input  noc_route_pkg::coord_t    dest,
    input  noc_route_pkg::port_enc_t destport,   // output port here, own position removed
    output noc_route_pkg::port_enc_t lkdestport  // output port at the next router
);

    noc_route_pkg::route_req_t   req;
    noc_route_pkg::port_onehot_t recv_port;
    noc_route_pkg::coord_t       next;
    noc_route_pkg::port_onehot_t lk_onehot;

    // registered request and mirrored receive port
    lookahead_ctrl #(
        .SW_LOC    (SW_LOC)
    ) u_ctrl (
        .clk       (clk),
        .reset     (reset),
        .dest      (dest),
        .destport  (destport),
        .req       (req),
        .recv_port (recv_port)
    );

    next_addr_predictor u_pred (
        .current   (current),
        .port      (req.port),
        .next      (next)
    );

    // routing decision as the next router will make it
    xy_route u_route (
        .here      (next),
        .dest      (req.dest),
        .port      (lk_onehot)
    );

    port_compactor u_compact (
        .lk_onehot  (lk_onehot),
        .recv_port  (recv_port),
        .lkdestport (lkdestport)
    );

endmodule

// File: bench/lookahead_route_assert.sv
/*
  assertion checker for the look-ahead XY routing unit
  bound to lookahead_route_top and written for a unit at the local port
  (SW_LOC 0), where destport bit i stands for router port i + 1
  each property rebuilds the rule from the previous cycle's inputs
*/

`timescale 1ns/100ps

module lookahead_route_assert (
    input logic                     clk,
    input logic                     reset,
    input noc_route_pkg::coord_t    current,
    input noc_route_pkg::coord_t    dest,
    input noc_route_pkg::port_enc_t destport,
    input noc_route_pkg::port_enc_t lkdestport
);

    localparam noc_route_pkg::port_enc_t GO_EAST =
        noc_route_pkg::port_enc_t'(1 << (noc_route_pkg::PORT_EAST - 1));

    int fail_count = 0;   // read by the testbench at the end of the run

    // address one hop away, in the direction given by destport
    function automatic noc_route_pkg::coord_t step_to(
        input noc_route_pkg::coord_t    cur,
        input noc_route_pkg::port_enc_t dp
    );
        noc_route_pkg::coord_t nxt;
        nxt = cur;
        if (dp == GO_EAST) begin
            nxt.x = noc_route_pkg::coord_x_t'(int'(cur.x) + 1);
        end else if (dp == 4'b0010) begin
            nxt.y = noc_route_pkg::coord_y_t'(int'(cur.y) - 1);   // north
        end else if (dp == 4'b0100) begin
            nxt.x = noc_route_pkg::coord_x_t'(int'(cur.x) - 1);
        end else if (dp == 4'b1000) begin
            nxt.y = noc_route_pkg::coord_y_t'(int'(cur.y) + 1);   // south
        end
        return nxt;
    endfunction

    // XY decision at the next router as a port number
    function automatic int next_port(
        input noc_route_pkg::coord_t    cur,
        input noc_route_pkg::coord_t    dst,
        input noc_route_pkg::port_enc_t dp
    );
        noc_route_pkg::coord_t h;
        h = step_to(cur, dp);
        if (dst.x != h.x) begin
            return (dst.x > h.x) ? noc_route_pkg::PORT_EAST : noc_route_pkg::PORT_WEST;
        end
        if (dst.y != h.y) begin
            return (dst.y > h.y) ? noc_route_pkg::PORT_SOUTH : noc_route_pkg::PORT_NORTH;
        end
        return noc_route_pkg::PORT_LOCAL;
    endfunction

    function automatic noc_route_pkg::port_enc_t lk_rule(
        input noc_route_pkg::coord_t    cur,
        input noc_route_pkg::coord_t    dst,
        input noc_route_pkg::port_enc_t dp
    );
        int lk;
        int rv;
        int idx;
        lk = next_port(cur, dst, dp);
        rv = 0;   // no move, receive index 0
        for (int i = 0; i < noc_route_pkg::PORTS - 1; i++) begin
            if (dp[i]) begin
                rv = ((i + 2) % 4) + 1;   // opposite side of port i + 1
            end
        end
        idx = (rv > lk) ? lk : lk - 1;
        if (idx < 0) begin
            idx = noc_route_pkg::PORTS - 2;
        end
        return noc_route_pkg::port_enc_t'(1 << idx);
    endfunction

    a_rule: assert property (@(posedge clk) (!reset && !$past(reset)) |->
        lkdestport == lk_rule(current, $past(dest), $past(destport)))
        else begin
            $error("look-ahead port does not follow the XY rule");
            fail_count = fail_count + 1;
        end

    a_onehot: assert property (@(posedge clk)
        (!reset && !$past(reset) && $onehot($past(destport))) |-> $onehot(lkdestport))
        else begin
            $error("look-ahead port is not one-hot after a one-hot request");
            fail_count = fail_count + 1;
        end

    // arrival at the next router, local stays at bit 0
    a_local: assert property (@(posedge clk)
        (!reset && !$past(reset) && $onehot($past(destport))
         && step_to(current, $past(destport)) == $past(dest)) |-> lkdestport[0])
        else begin
            $error("local port missing when the next router is the destination");
            fail_count = fail_count + 1;
        end

    a_east_through: assert property (@(posedge clk)
        (!reset && !$past(reset) && $past(destport) == GO_EAST
         && next_port(current, $past(dest), $past(destport)) == noc_route_pkg::PORT_EAST)
        |-> lkdestport == 4'b0010)
        else begin
            $error("east after east is not at compacted index 1");
            fail_count = fail_count + 1;
        end

    // west receive port removed, south moves down to index 3
    a_east_turn_south: assert property (@(posedge clk)
        (!reset && !$past(reset) && $past(destport) == GO_EAST
         && next_port(current, $past(dest), $past(destport)) == noc_route_pkg::PORT_SOUTH)
        |-> lkdestport == 4'b1000)
        else begin
            $error("south turn after east is not at compacted index 3");
            fail_count = fail_count + 1;
        end

    a_reset_release: assert property (@(posedge clk) (!reset && $past(reset)) |->
        lkdestport == lk_rule(current, '0, '0))
        else begin
            $error("first cycle after reset does not match the zero request");
            fail_count = fail_count + 1;
        end

endmodule

// File: bench/tb_lookahead_route.sv
/*
  testbench for the look-ahead XY routing unit, DUT at the local port
  drives a reset release, a few directed turns and a sweep of random
  requests over all routers, then checks every result one clock later
  the bound assertion module checks the same rules in parallel
*/

`timescale 1ns/100ps

module tb_lookahead_route;

    localparam int CYCLE_LIMIT     = 1000;
    localparam int REQS_PER_ROUTER = 6;

    // destport codes, bit i is router port i + 1 since local is removed
    localparam noc_route_pkg::port_enc_t ENC_EAST =
        noc_route_pkg::port_enc_t'(1 << (noc_route_pkg::PORT_EAST - 1));
    localparam noc_route_pkg::port_enc_t ENC_NORTH =
        noc_route_pkg::port_enc_t'(1 << (noc_route_pkg::PORT_NORTH - 1));
    localparam noc_route_pkg::port_enc_t ENC_WEST =
        noc_route_pkg::port_enc_t'(1 << (noc_route_pkg::PORT_WEST - 1));
    localparam noc_route_pkg::port_enc_t ENC_SOUTH =
        noc_route_pkg::port_enc_t'(1 << (noc_route_pkg::PORT_SOUTH - 1));

    logic                     clk;
    logic                     reset;
    noc_route_pkg::coord_t    current;
    noc_route_pkg::coord_t    dest;
    noc_route_pkg::port_enc_t destport;
    noc_route_pkg::port_enc_t lkdestport;

    logic [31:0]              lfsr_state;
    int                       checks;
    int                       errors;
    noc_route_pkg::coord_t    last_dest;   // request waiting for its result
    noc_route_pkg::port_enc_t last_dp;
    string                    last_name;

    lookahead_route_top #(
        .SW_LOC     (0)
    ) dut0 (
        .clk        (clk),
        .reset      (reset),
        .current    (current),
        .dest       (dest),
        .destport   (destport),
        .lkdestport (lkdestport)
    );

    bind lookahead_route_top lookahead_route_assert u_chk (
        .clk        (clk),
        .reset      (reset),
        .current    (current),
        .dest       (dest),
        .destport   (destport),
        .lkdestport (lkdestport)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic noc_route_pkg::coord_t make_coord(input int x, input int y);
        noc_route_pkg::coord_t c;
        c.x = noc_route_pkg::coord_x_t'(x);
        c.y = noc_route_pkg::coord_y_t'(y);
        return c;
    endfunction

    // fibonacci LFSR x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic int take_bits(input int n);
        int   val;
        logic fb;
        val = 0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            val = (val << 1) | int'(fb);
        end
        return val;
    endfunction

    function automatic noc_route_pkg::coord_t random_coord();
        int x;
        int y;
        x = take_bits(noc_route_pkg::XW);
        y = take_bits(noc_route_pkg::YW);
        return make_coord(x, y);
    endfunction

    // dimension order: x first, then y, then local
    function automatic int xy_index(input noc_route_pkg::coord_t here,
                                    input noc_route_pkg::coord_t dst);
        if (dst.x > here.x) return noc_route_pkg::PORT_EAST;
        if (dst.x < here.x) return noc_route_pkg::PORT_WEST;
        if (dst.y > here.y) return noc_route_pkg::PORT_SOUTH;   // y grows southward
        if (dst.y < here.y) return noc_route_pkg::PORT_NORTH;
        return noc_route_pkg::PORT_LOCAL;
    endfunction

    // local cannot be expressed here, so it becomes no port at all
    function automatic noc_route_pkg::port_enc_t enc_of(input int port);
        if (port == noc_route_pkg::PORT_LOCAL) return '0;
        return noc_route_pkg::port_enc_t'(1 << (port - 1));
    endfunction

    function automatic noc_route_pkg::port_enc_t expect_lk(
        input noc_route_pkg::coord_t    cur,
        input noc_route_pkg::coord_t    dst,
        input noc_route_pkg::port_enc_t dp
    );
        noc_route_pkg::coord_t nxt;
        int from;    // port of entry at the next router
        int go;
        int pos;
        nxt = cur;
        from = noc_route_pkg::PORT_LOCAL;
        case (dp)
            ENC_EAST: begin
                nxt.x = noc_route_pkg::coord_x_t'(int'(cur.x) + 1);
                from = noc_route_pkg::PORT_WEST;
            end
            ENC_WEST: begin
                nxt.x = noc_route_pkg::coord_x_t'(int'(cur.x) - 1);
                from = noc_route_pkg::PORT_EAST;
            end
            ENC_NORTH: begin
                nxt.y = noc_route_pkg::coord_y_t'(int'(cur.y) - 1);
                from = noc_route_pkg::PORT_SOUTH;
            end
            ENC_SOUTH: begin
                nxt.y = noc_route_pkg::coord_y_t'(int'(cur.y) + 1);
                from = noc_route_pkg::PORT_NORTH;
            end
            default: ;
        endcase
        go = xy_index(nxt, dst);
        pos = (from > go) ? go : go - 1;
        if (pos < 0) begin
            pos = noc_route_pkg::PORTS - 2;   // local against index 0 lands on top
        end
        return noc_route_pkg::port_enc_t'(1 << pos);
    endfunction

    task automatic check_port(input string name, input noc_route_pkg::port_enc_t want,
                              input noc_route_pkg::port_enc_t got);
        checks++;
        if (got !== want) begin
            errors++;
            $display("ERR %s expected %b actual %b", name, want, got);
        end
    endtask

    // new inputs on this edge, result of the previous request at the negedge
    task automatic apply(input noc_route_pkg::coord_t cur, input noc_route_pkg::coord_t dst,
                         input noc_route_pkg::port_enc_t dp, input string name);
        noc_route_pkg::port_enc_t want;
        @(posedge clk);
        current  <= cur;
        dest     <= dst;
        destport <= dp;
        @(negedge clk);
        want = expect_lk(cur, last_dest, last_dp);
        check_port(last_name, want, lkdestport);
        last_dest = dst;
        last_dp   = dp;
        last_name = name;
    endtask

    task automatic release_reset();
        noc_route_pkg::port_enc_t want;
        @(posedge clk);
        reset    <= 1'b0;
        dest     <= '0;
        destport <= '0;
        @(negedge clk);
        want = expect_lk(current, '0, '0);   // register still at reset value
        check_port("reset_release", want, lkdestport);
        last_dest = '0;
        last_dp   = '0;
        last_name = "zero_request";
    endtask

    // watchdog for the whole run
    initial begin
        for (int c = 0; c < CYCLE_LIMIT; c++) begin
            @(posedge clk);
        end
        $display("timeout: stimulus did not finish within %0d cycles", CYCLE_LIMIT);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        noc_route_pkg::coord_t cur;
        noc_route_pkg::coord_t dst;
        int                    afails;
        reset      <= 1'b1;
        current    <= make_coord(2, 3);
        dest       <= '0;
        destport   <= '0;
        lfsr_state = 32'h7443ba72;
        checks     = 0;
        errors     = 0;
        @(posedge clk);
        release_reset();

        // straight through east, then an east move turning south and arriving
        apply(make_coord(1, 0), make_coord(3, 0), ENC_EAST, "east_through");
        apply(make_coord(1, 0), make_coord(1, 0), '0, "idle");
        apply(make_coord(2, 1), make_coord(3, 3), ENC_EAST, "east_then_south");
        apply(make_coord(2, 1), make_coord(2, 2), ENC_SOUTH, "arrive_south");
        apply(make_coord(2, 1), make_coord(2, 1), '0, "idle");

        // back-to-back requests at every router, idle before current moves
        for (int y = 0; y < noc_route_pkg::NY; y++) begin
            for (int x = 0; x < noc_route_pkg::NX; x++) begin
                cur = make_coord(x, y);
                for (int n = 0; n < REQS_PER_ROUTER; n++) begin
                    dst = random_coord();
                    apply(cur, dst, enc_of(xy_index(cur, dst)), "xy_stream");
                end
                apply(cur, cur, '0, "idle");
            end
        end
        apply(cur, cur, '0, "flush");
        @(posedge clk);   // let the last assertions fire
        @(negedge clk);

        afails = dut0.u_chk.fail_count;
        $display("checks %0d, errors %0d, assertion failures %0d", checks, errors, afails);
        if (errors == 0 && afails == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: all.f
hw/noc_route_pkg.sv
hw/lookahead_ctrl.sv
hw/next_addr_predictor.sv
hw/xy_route.sv
hw/port_compactor.sv
hw/lookahead_route_top.sv
bench/lookahead_route_assert.sv
bench/tb_lookahead_route.sv

// File: run.sh
#!/usr/bin/env bash
# builds the look-ahead router testbench with Verilator and runs it
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG_FILE="$BUILD_DIR/sim.log"

if ! mkdir -p "$BUILD_DIR"; then
    echo "cannot create $BUILD_DIR"
    exit 1
fi

if ! verilator --binary --timing --assert --timescale 1ns/100ps \
        --top-module tb_lookahead_route -Mdir "$BUILD_DIR/obj_dir" -o sim -f all.f; then
    echo "build failed"
    exit 1
fi

"$BUILD_DIR/obj_dir/sim" +verilator+error+limit+1000 > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "TEST OK" "$LOG_FILE"; then
    exit 0
fi
echo "pass message not found in $LOG_FILE"
exit 1
